// ==== hw/pcs_rx_defs.svh ====
`ifndef PCS_RX_DEFS_SVH
`define PCS_RX_DEFS_SVH

// coded block layout
`define PCS_NB_CODED_BLOCK  66
`define PCS_NB_SH           2
`define PCS_NB_PAYLOAD      (`PCS_NB_CODED_BLOCK - `PCS_NB_SH)

// lock monitor limits
`define PCS_MAX_WINDOW      4096
`define PCS_NB_WINDOW_CNT   $clog2(`PCS_MAX_WINDOW)             // 12
`define PCS_MAX_INVALID_SH  (`PCS_MAX_WINDOW / 2)
`define PCS_NB_INVALID_CNT  $clog2(`PCS_MAX_INVALID_SH)         // 11

// bit offset of a block inside two groups
`define PCS_NB_INDEX        $clog2(`PCS_NB_CODED_BLOCK)         // 7

`endif

// ==== hw/pcs_rx_pkg.sv ====
`include "pcs_rx_defs.svh"

package pcs_rx_pkg;

    // one aligned 66-bit block, header in the top two bits
    typedef struct packed
    {
        logic [`PCS_NB_SH-1:0]      sh;         // 01 data, 10 control
        logic [`PCS_NB_PAYLOAD-1:0] payload;    // first received bit at msb
    } coded_block_t;

    // static configuration of the block synchronizer
    typedef struct packed
    {
        logic [`PCS_NB_WINDOW_CNT-1:0]  unlocked_limit;    // valid headers in a row to lock
        logic [`PCS_NB_WINDOW_CNT-1:0]  locked_window;     // groups per monitoring window
        logic [`PCS_NB_INVALID_CNT-1:0] invalid_limit;     // invalid headers per window to unlock
    } sync_cfg_t;

    // lock state machine
    // slip is a single cycle step between two search attempts
    typedef enum logic [1:0]
    {
        SYNC_SEARCH = 2'd0,
        SYNC_SLIP   = 2'd1,
        SYNC_LOCKED = 2'd2
    } sync_state_t;

endpackage

// ==== hw/rx_deserializer.sv ====
`include "pcs_rx_defs.svh"

module rx_deserializer
(
    input  logic                            i_clock,
    input  logic                            i_arst_n,
    input  logic                            i_enable,
    input  logic                            i_signal_ok,
    input  logic                            i_bit,
    input  logic                            i_bit_valid,
    output logic [`PCS_NB_CODED_BLOCK-1:0]  o_group,
    output logic                            o_group_valid
);

    localparam int LAST_BIT = `PCS_NB_CODED_BLOCK - 1;

    logic [`PCS_NB_CODED_BLOCK-1:0] shift_reg;
    logic [`PCS_NB_INDEX-1:0]       bit_cnt;
    logic                           accept;
    logic                           last_bit;

    assign accept   = i_enable & i_signal_ok & i_bit_valid;
    assign last_bit = (bit_cnt == LAST_BIT[`PCS_NB_INDEX-1:0]);

    // bit counter and group strobe
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            bit_cnt       <= '0;
            o_group_valid <= 1'b0;
        end
        else if (!i_signal_ok)
        begin
            bit_cnt       <= '0;
            o_group_valid <= 1'b0;
        end
        else if (i_enable)  // strobe is held while disabled, block_sync consumes it once
        begin
            o_group_valid <= i_bit_valid & last_bit;
            if (i_bit_valid)
                bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
        end
    end

    // first bit of a group ends up at the msb
    always_ff @(posedge i_clock)
    begin
        if (accept)
        begin
            shift_reg <= {shift_reg[`PCS_NB_CODED_BLOCK-2:0], i_bit};
            if (last_bit)
                o_group <= {shift_reg[`PCS_NB_CODED_BLOCK-2:0], i_bit};
        end
    end

endmodule

// ==== hw/block_sync_fsm.sv ====
`include "pcs_rx_defs.svh"

module block_sync_fsm
(
    input  logic                        i_clock,
    input  logic                        i_arst_n,
    input  logic                        i_enable,
    input  logic                        i_signal_ok,
    input  logic                        i_valid,        // one strobe per received group
    input  logic                        i_sh_valid,     // header at search offset is 01 or 10
    input  pcs_rx_pkg::sync_cfg_t       i_cfg,
    output logic [`PCS_NB_INDEX-1:0]    o_search_index,
    output logic [`PCS_NB_INDEX-1:0]    o_block_index,
    output logic                        o_block_lock    // lock as decided by this cycle
);

    localparam int LAST_INDEX = `PCS_NB_CODED_BLOCK - 1;

    pcs_rx_pkg::sync_state_t        state;
    pcs_rx_pkg::sync_state_t        state_next;

    logic [`PCS_NB_WINDOW_CNT-1:0]  valid_cnt;
    logic [`PCS_NB_WINDOW_CNT-1:0]  window_cnt;
    logic [`PCS_NB_INVALID_CNT-1:0] invalid_cnt;
    logic [`PCS_NB_INDEX-1:0]       search_index;
    logic [`PCS_NB_INDEX-1:0]       block_index;

    logic [`PCS_NB_WINDOW_CNT-1:0]  valid_cnt_inc;
    logic [`PCS_NB_WINDOW_CNT-1:0]  window_cnt_inc;
    logic [`PCS_NB_INVALID_CNT-1:0] invalid_cnt_inc;
    logic [`PCS_NB_INDEX-1:0]       slip_index;
    logic                           lock_reached;
    logic                           lock_lost;
    logic                           window_done;

    assign valid_cnt_inc   = valid_cnt + 1'b1;
    assign window_cnt_inc  = window_cnt + 1'b1;
    assign invalid_cnt_inc = invalid_cnt + 1'b1;

    // next offset to try, wraps after the last bit of the block
    assign slip_index = (search_index == LAST_INDEX[`PCS_NB_INDEX-1:0]) ? '0
                                                                        : search_index + 1'b1;

    assign lock_reached = i_sh_valid & (valid_cnt_inc == i_cfg.unlocked_limit);
    assign lock_lost    = ~i_sh_valid & (invalid_cnt_inc == i_cfg.invalid_limit);
    assign window_done  = (window_cnt_inc == i_cfg.locked_window);

    always_comb
    begin
        state_next = state;
        if (!i_signal_ok)
            state_next = pcs_rx_pkg::SYNC_SEARCH;
        else if (i_enable)
        begin
            case (state)
                pcs_rx_pkg::SYNC_SEARCH:
                begin
                    if (i_valid && !i_sh_valid)
                        state_next = pcs_rx_pkg::SYNC_SLIP;
                    else if (i_valid && lock_reached)
                        state_next = pcs_rx_pkg::SYNC_LOCKED;
                end
                pcs_rx_pkg::SYNC_SLIP:
                    state_next = pcs_rx_pkg::SYNC_SEARCH;
                pcs_rx_pkg::SYNC_LOCKED:
                begin
                    if (i_valid && lock_lost)
                        state_next = pcs_rx_pkg::SYNC_SLIP;
                end
                default:
                    state_next = pcs_rx_pkg::SYNC_SEARCH;
            endcase
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state        <= pcs_rx_pkg::SYNC_SEARCH;
            valid_cnt    <= '0;
            window_cnt   <= '0;
            invalid_cnt  <= '0;
            search_index <= '0;
            block_index  <= '0;
        end
        else if (!i_signal_ok)
        begin
            // offsets are kept, the next search starts where the last lock was
            state       <= pcs_rx_pkg::SYNC_SEARCH;
            valid_cnt   <= '0;
            window_cnt  <= '0;
            invalid_cnt <= '0;
        end
        else if (i_enable)
        begin
            state <= state_next;
            if (i_valid && state == pcs_rx_pkg::SYNC_SEARCH)
            begin
                valid_cnt <= valid_cnt_inc;
                if (!i_sh_valid)
                begin
                    valid_cnt    <= '0;
                    search_index <= slip_index;
                end
                else if (lock_reached)
                begin
                    valid_cnt   <= '0;
                    window_cnt  <= '0;
                    invalid_cnt <= '0;
                    block_index <= search_index;
                end
            end
            else if (i_valid && state == pcs_rx_pkg::SYNC_LOCKED)
            begin
                window_cnt <= window_cnt_inc;
                if (!i_sh_valid)
                    invalid_cnt <= invalid_cnt_inc;
                if (lock_lost)
                begin
                    window_cnt   <= '0;
                    invalid_cnt  <= '0;
                    search_index <= slip_index;
                end
                else if (window_done)   // new window
                begin
                    window_cnt  <= '0;
                    invalid_cnt <= '0;
                end
            end
        end
    end

    assign o_search_index = search_index;
    assign o_block_index  = block_index;
    assign o_block_lock   = (state_next == pcs_rx_pkg::SYNC_LOCKED);

endmodule

// ==== hw/block_sync.sv ====
`include "pcs_rx_defs.svh"

module block_sync
(
    input  logic                            i_clock,
    input  logic                            i_arst_n,
    input  logic                            i_enable,
    input  logic                            i_signal_ok,
    input  logic [`PCS_NB_CODED_BLOCK-1:0]  i_data,
    input  logic                            i_valid,
    input  pcs_rx_pkg::sync_cfg_t           i_cfg,
    output pcs_rx_pkg::coded_block_t        o_block,
    output logic                            o_valid,
    output logic                            o_block_lock
);

    localparam int NB_EXT  = 2 * `PCS_NB_CODED_BLOCK;
    localparam int EXT_MSB = NB_EXT - 1;

    logic [`PCS_NB_CODED_BLOCK-1:0] data_prev;
    logic [NB_EXT-1:0]              data_ext;
    logic [`PCS_NB_CODED_BLOCK-1:0] aligned;
    logic [`PCS_NB_INDEX-1:0]       search_index;
    logic [`PCS_NB_INDEX-1:0]       block_index;
    logic                           sh_valid;
    logic                           lock_next;

    // older group on top so the stream reads msb first across both
    assign data_ext = {data_prev, i_data};

    assign sh_valid = ^data_ext[EXT_MSB - search_index -: `PCS_NB_SH];
    assign aligned  = data_ext[EXT_MSB - block_index -: `PCS_NB_CODED_BLOCK];

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
            data_prev <= '0;
        else if (!i_signal_ok)
            data_prev <= '0;
        else if (i_enable && i_valid)
            data_prev <= i_data;
    end

    // lock_next already falls when signal_ok drops
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_valid      <= 1'b0;
            o_block_lock <= 1'b0;
        end
        else
        begin
            o_valid      <= i_enable & i_valid & lock_next;
            o_block_lock <= lock_next;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_enable && i_valid)
            o_block <= aligned;
    end

    block_sync_fsm u_block_sync_fsm
    (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_enable       (i_enable),
        .i_signal_ok    (i_signal_ok),
        .i_valid        (i_valid),
        .i_sh_valid     (sh_valid),
        .i_cfg          (i_cfg),
        .o_search_index (search_index),
        .o_block_index  (block_index),
        .o_block_lock   (lock_next)
    );

endmodule

// ==== hw/rx_descrambler.sv ====
`include "pcs_rx_defs.svh"

// self-synchronizing descrambler, 1 + x^39 + x^58
module rx_descrambler
(
    input  logic                        i_clock,
    input  logic                        i_arst_n,
    input  pcs_rx_pkg::coded_block_t    i_block,
    input  logic                        i_valid,
    output pcs_rx_pkg::coded_block_t    o_block,
    output logic                        o_valid
);

    localparam int NB_HIST = 58;       // longest tap
    localparam int TAP     = 39;
    localparam int NB_EXT  = NB_HIST + `PCS_NB_PAYLOAD;

    logic [NB_HIST-1:0]         history;
    logic [NB_EXT-1:0]          scr_ext;
    logic [`PCS_NB_PAYLOAD-1:0] descrambled;

    // oldest received bit at the msb, so bit p sees p+39 and p+58 as earlier bits
    assign scr_ext = {history, i_block.payload};

    assign descrambled = scr_ext[`PCS_NB_PAYLOAD-1:0]
                       ^ scr_ext[TAP +: `PCS_NB_PAYLOAD]
                       ^ scr_ext[NB_HIST +: `PCS_NB_PAYLOAD];

    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            history <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
            if (i_valid)
                history <= i_block.payload[NB_HIST-1:0];  // history holds scrambled bits
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_block.sh      <= i_block.sh;   // header is not scrambled
            o_block.payload <= descrambled;
        end
    end

endmodule

// ==== hw/pcs_rx_top.sv ====
`include "pcs_rx_defs.svh"

module pcs_rx_top
(
    input  logic                        i_clock,
    input  logic                        i_arst_n,
    input  logic                        i_enable,
    input  logic                        i_signal_ok,
    input  logic                        i_bit,
    input  logic                        i_bit_valid,
    input  pcs_rx_pkg::sync_cfg_t       i_cfg,
    output pcs_rx_pkg::coded_block_t    o_block,
    output logic                        o_block_valid,
    output logic                        o_block_lock
);

    logic [`PCS_NB_CODED_BLOCK-1:0] group;
    logic                           group_valid;
    pcs_rx_pkg::coded_block_t       aligned_block;
    logic                           aligned_valid;

    rx_deserializer u_rx_deserializer
    (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_enable       (i_enable),
        .i_signal_ok    (i_signal_ok),
        .i_bit          (i_bit),
        .i_bit_valid    (i_bit_valid),
        .o_group        (group),
        .o_group_valid  (group_valid)
    );

    block_sync u_block_sync
    (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_enable       (i_enable),
        .i_signal_ok    (i_signal_ok),
        .i_data         (group),
        .i_valid        (group_valid),
        .i_cfg          (i_cfg),
        .o_block        (aligned_block),
        .o_valid        (aligned_valid),
        .o_block_lock   (o_block_lock)
    );

    rx_descrambler u_rx_descrambler
    (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_block        (aligned_block),
        .i_valid        (aligned_valid),
        .o_block        (o_block),
        .o_valid        (o_block_valid)
    );

endmodule

// ==== tests/pcs_rx_assertions.sv ====
module pcs_rx_assertions
(
    input  logic    i_clock,
    input  logic    i_arst_n,
    input  logic    i_signal_ok,
    input  logic    i_block_valid,
    input  logic    i_block_lock
);

    // a block in flight when signal_ok drops still leaves the descrambler
    valid_needs_lock: assert property (
        @(posedge i_clock) disable iff (!i_arst_n || !i_signal_ok)
        i_block_valid |-> i_block_lock
    ) else $error("block valid without block lock");

    valid_single_cycle: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        i_block_valid |=> !i_block_valid
    ) else $error("block valid on two cycles in a row");

    lock_cleared: assert property (
        @(posedge i_clock) disable iff (!i_arst_n)
        !i_signal_ok |=> !i_block_lock
    ) else $error("block lock high while signal_ok is low");

endmodule

bind pcs_rx_top pcs_rx_assertions u_assertions
(
    .i_clock        (i_clock),
    .i_arst_n       (i_arst_n),
    .i_signal_ok    (i_signal_ok),
    .i_block_valid  (o_block_valid),
    .i_block_lock   (o_block_lock)
);

// ==== tests/pcs_rx_tb.sv ====
`include "pcs_rx_defs.svh"

module pcs_rx_tb;

    localparam int NB_BLK = `PCS_NB_CODED_BLOCK;
    localparam int GROUP  = NB_BLK;     // clocks per group, one bit per clock

    logic                       i_clock;
    logic                       i_arst_n;
    logic                       i_enable;
    logic                       i_signal_ok;
    logic                       i_bit;
    logic                       i_bit_valid;
    pcs_rx_pkg::sync_cfg_t      i_cfg;
    pcs_rx_pkg::coded_block_t   o_block;
    logic                       o_block_valid;
    logic                       o_block_lock;

    integer                     seed = 62198;
    pcs_rx_pkg::coded_block_t   expected[$];    // unscrambled blocks in send order
    logic                       tx_on;
    logic                       check_en;
    int                         junk_bits = 0;
    int                         blk_no = 0;
    int                         corrupt_from = 0;
    int                         corrupt_to = 0;
    int                         corrupt_period = 0;
    int                         n_checked = 0;

    pcs_rx_top uut
    (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_enable       (i_enable),
        .i_signal_ok    (i_signal_ok),
        .i_bit          (i_bit),
        .i_bit_valid    (i_bit_valid),
        .i_cfg          (i_cfg),
        .o_block        (o_block),
        .o_block_valid  (o_block_valid),
        .o_block_lock   (o_block_lock)
    );

    always #50 i_clock = ~i_clock;

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_block(input pcs_rx_pkg::coded_block_t got,
                               input pcs_rx_pkg::coded_block_t exp);
        if (got !== exp)
        begin
            $display("FAIL %0t: block sh=%b payload=%h, expected sh=%b payload=%h",
                     $time, got.sh, got.payload, exp.sh, exp.payload);
            stop_run();
        end
    endtask

    task automatic check_lock(input logic exp);
        if (o_block_lock !== exp)
        begin
            $display("FAIL %0t: o_block_lock is %b, expected %b", $time, o_block_lock, exp);
            stop_run();
        end
    endtask

    task automatic check_valid(input logic exp);
        if (o_block_valid !== exp)
        begin
            $display("FAIL %0t: o_block_valid is %b, expected %b", $time, o_block_valid, exp);
            stop_run();
        end
    endtask

    // scrambler 1 + x^39 + x^58 and msb-first serializer
    initial
    begin : sender
        pcs_rx_pkg::coded_block_t   blk;
        logic [57:0]                scr;
        logic [NB_BLK-1:0]          word;
        logic                       b;
        int                         k;
        i_bit       = 1'b0;
        i_bit_valid = 1'b0;
        scr         = '0;
        wait (tx_on);
        repeat (junk_bits)
        begin
            @(posedge i_clock);
            #1;
            i_bit       = 1'($random(seed));
            i_bit_valid = 1'b1;
        end
        forever
        begin
            blk.payload = {$random(seed), $random(seed)};
            blk.sh      = (($random(seed) & 1) != 0) ? 2'b10 : 2'b01;
            if ((blk_no >= corrupt_from && blk_no < corrupt_to) ||
                (corrupt_period != 0 && (blk_no % corrupt_period) < 3))
                blk.sh = {blk.sh[0], blk.sh[0]};    // 00 or 11
            expected.push_back(blk);
            word[65:64] = blk.sh;
            for (k = 63; k >= 0; k--)
            begin
                b       = blk.payload[k] ^ scr[38] ^ scr[57];
                word[k] = b;
                scr     = {scr[56:0], b};   // scr[0] is the latest sent bit
            end
            blk_no++;
            for (k = NB_BLK - 1; k >= 0; k--)
            begin
                @(posedge i_clock);
                #1;
                i_bit       = word[k];
                i_bit_valid = 1'b1;
            end
        end
    end

    // output checker, finds its place in the queue again after each relock
    initial
    begin : block_checker
        pcs_rx_pkg::coded_block_t   exp;
        int                         idx;
        logic                       synced;
        synced = 1'b0;
        forever
        begin
            @(negedge i_clock);
            if (!check_en)
                synced = 1'b0;
            else if (o_block_valid)
            begin
                if (!synced)
                begin
                    idx = -1;
                    foreach (expected[i])
                        if (idx < 0 && expected[i] == o_block)
                            idx = i;
                    if (idx < 0)
                    begin
                        $display("Output block after lock matches no block that was sent");
                        stop_run();
                    end
                    repeat (idx) expected.delete(0);
                    synced = 1'b1;
                end
                exp = expected.pop_front();
                check_block(o_block, exp);
                n_checked++;
            end
        end
    end

    task automatic wait_lock(input logic level, input int max_cycles, input string what);
        int n;
        n = 0;
        while (o_block_lock !== level)
        begin
            @(negedge i_clock);
            n++;
            if (n > max_cycles)
            begin
                $display("Timed out waiting for %s", what);
                stop_run();
            end
        end
    endtask

    // lock must stay up over more than one monitoring window
    task automatic wait_stable_lock(input int max_cycles);
        int run;
        int n;
        run = 0;
        n   = 0;
        while (run < 40 * GROUP)
        begin
            @(negedge i_clock);
            n++;
            run = o_block_lock ? run + 1 : 0;
            if (n > max_cycles)
            begin
                $display("Timed out waiting for a stable lock");
                stop_run();
            end
        end
    endtask

    task automatic wait_checked(input int count);
        int target;
        int n;
        target = n_checked + count;
        n      = 0;
        while (n_checked < target)
        begin
            @(negedge i_clock);
            n++;
            if (n > (count + 4) * GROUP)
            begin
                $display("Timed out waiting for checked output blocks");
                stop_run();
            end
        end
    endtask

    task automatic relock_and_check(input int max_cycles, input int count);
        wait_lock(1'b1, max_cycles, "block lock");
        wait_stable_lock(max_cycles);
        check_en = 1'b1;
        wait_checked(count);
    endtask

    task automatic test_idle();
        repeat (5 * GROUP)
        begin
            @(negedge i_clock);
            check_lock(1'b0);
            check_valid(1'b0);
        end
    endtask

    task automatic test_acquire();
        int j;
        j         = $unsigned($random(seed)) % NB_BLK;
        junk_bits = j;
        tx_on     = 1'b1;
        relock_and_check(GROUP * (NB_BLK * (j + 8) + 20), 40);
    endtask

    task automatic test_loss();
        corrupt_from = blk_no + 1;
        corrupt_to   = corrupt_from + 7;    // any 16-group window split leaves 4 in one
        wait_lock(1'b0, 40 * GROUP, "loss of lock");
        check_en = 1'b0;
        relock_and_check(1000 * GROUP, 30);
    endtask

    task automatic test_tolerance();
        corrupt_period = 16;    // exactly three bad headers in any 16 blocks
        repeat (6 * 16 * GROUP)
        begin
            @(negedge i_clock);
            check_lock(1'b1);
        end
        corrupt_period = 0;
        wait_checked(10);
    endtask

    task automatic test_signal_ok();
        check_en = 1'b0;
        @(posedge i_clock);
        #1 i_signal_ok = 1'b0;
        repeat (2) @(negedge i_clock);
        repeat (10)
        begin
            @(negedge i_clock);
            check_lock(1'b0);
        end
        @(posedge i_clock);
        #1 i_signal_ok = 1'b1;
        relock_and_check(1000 * GROUP, 20);
    endtask

    task automatic test_enable();
        logic held;
        check_en = 1'b0;
        held     = o_block_lock;
        @(posedge i_clock);
        #1 i_enable = 1'b0;
        repeat (2) @(negedge i_clock);  // blocks already past block_sync may still show
        repeat (5 * GROUP)
        begin
            @(negedge i_clock);
            check_valid(1'b0);
            check_lock(held);
        end
    endtask

    initial
    begin
        i_clock     = 1'b0;
        i_arst_n    = 1'b0;
        i_enable    = 1'b1;
        i_signal_ok = 1'b1;
        i_cfg       = '{unlocked_limit: 12'd8, locked_window: 12'd16, invalid_limit: 11'd4};
        tx_on       = 1'b0;
        check_en    = 1'b0;
        repeat (3) @(posedge i_clock);
        #1 i_arst_n = 1'b1;

        test_idle();
        test_acquire();
        test_loss();
        test_tolerance();
        test_signal_ok();
        test_enable();

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/pcs_rx_pkg.sv
hw/rx_deserializer.sv
hw/block_sync_fsm.sv
hw/block_sync.sv
hw/rx_descrambler.sv
hw/pcs_rx_top.sv
tests/pcs_rx_assertions.sv
tests/pcs_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pcs_rx_tb
FILELIST  ?= sources.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
